/* field_extractor.sv */
// type and length field extractor

`timescale 1ns/10ps

module field_extractor (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            valid_i,
	input  parser_pkg::phv_t                phv_i,
	input  logic [parser_pkg::HDR_W-1:0]    located_i,
	output logic                            valid_o,
	output parser_pkg::phv_t                phv_o,
	output logic [parser_pkg::FIELD_W-1:0]  type_field_o,
	output logic [parser_pkg::FIELD_W-1:0]  len_field_o
);

	localparam int WORD_W     = 64;
	localparam int NUM_WORDS  = parser_pkg::HDR_BYTES * 8 / WORD_W;
	localparam int NUM_HALVES = WORD_W / parser_pkg::FIELD_W;

	logic [NUM_WORDS-1:0][WORD_W-1:0] words;
	logic [WORD_W-1:0]                type_word;
	logic [WORD_W-1:0]                len_word;
	logic                             valid_d1;
	parser_pkg::phv_t                 phv_d1;

	assign words = located_i;

	// word 0 holds the top bytes of the located header
	function automatic logic [WORD_W-1:0] pick_word(
		input logic [NUM_WORDS-1:0][WORD_W-1:0] w,
		input logic [2:0]                       idx
	);
		pick_word = w[3'(NUM_WORDS-1) - idx];
	endfunction

	function automatic logic [parser_pkg::FIELD_W-1:0] pick_half(
		input logic [WORD_W-1:0] word,
		input logic [1:0]        idx
	);
		logic [NUM_HALVES-1:0][parser_pkg::FIELD_W-1:0] halves;
		halves    = word;
		pick_half = halves[2'(NUM_HALVES-1) - idx];
	endfunction

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_d1 <= 1'b0;
			valid_o  <= 1'b0;
		end else begin
			valid_d1 <= valid_i;
			valid_o  <= valid_d1;
		end
	end

	always_ff @(posedge clk) begin
		type_word    <= pick_word(words, phv_i.ctrl.type_off[5:3]);
		len_word     <= pick_word(words, phv_i.ctrl.len_off[5:3]);
		phv_d1       <= phv_i;
		type_field_o <= pick_half(type_word, phv_d1.ctrl.type_off[2:1]);	// bit 0 ignored
		len_field_o  <= pick_half(len_word, phv_d1.ctrl.len_off[2:1]);
		phv_o        <= phv_d1;
	end

	// fields leave exactly two cycles after the vector arrives
	assert property (@(posedge clk) disable iff (!reset) valid_o == $past(valid_i, 2))
		else $error("field_extractor valid out of step with input");

endmodule

/* header_locator.sv */
// header locator
// rotates the packet header so the current protocol starts at byte 0

`timescale 1ns/10ps

module header_locator (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          valid_i,
	input  parser_pkg::phv_t              phv_i,
	output logic                          valid_o,
	output parser_pkg::phv_t              phv_o,
	output logic [parser_pkg::HDR_W-1:0]  located_o
);

	localparam int HW = parser_pkg::HDR_W;

	logic             valid_d1;
	parser_pkg::phv_t phv_d1;
	logic [HW-1:0]    word_rot;	// header after the 64-bit rotation
	logic [2*HW-1:0]  word_dbl;
	logic [2*HW-1:0]  byte_dbl;

	// rotate left through a doubled copy, upper half is the result
	assign word_dbl = {phv_i.pkt_hdr, phv_i.pkt_hdr} << {phv_i.hdr_offset[5:3], 6'd0};
	assign byte_dbl = {word_rot, word_rot} << {phv_d1.hdr_offset[2:0], 3'd0};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_d1 <= 1'b0;
			valid_o  <= 1'b0;
		end else begin
			valid_d1 <= valid_i;
			valid_o  <= valid_d1;
		end
	end

	always_ff @(posedge clk) begin
		word_rot  <= word_dbl[2*HW-1 -: HW];	// stage 1, word aligned
		phv_d1    <= phv_i;
		located_o <= byte_dbl[2*HW-1 -: HW];	// stage 2, byte aligned
		phv_o     <= phv_d1;
	end

endmodule

/* next_header_calc.sv */
// next header offset and stage output register

`timescale 1ns/10ps

module next_header_calc (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            valid_i,
	input  parser_pkg::phv_t                phv_i,
	input  logic [parser_pkg::FIELD_W-1:0]  len_field_i,
	input  parser_pkg::parse_ctrl_t         hit_action_i,
	output logic                            phv_valid_o,
	output parser_pkg::phv_t                phv_o
);

	logic                                valid_d1;
	logic                                valid_d2;
	parser_pkg::phv_t                    phv_d1;
	parser_pkg::phv_t                    phv_d2;
	logic [parser_pkg::LEN_W-1:0]        len_masked;
	logic [parser_pkg::LEN_W-1:0]        len_sel;
	logic [parser_pkg::OFFSET_W-1:0]     next_offset;

	// shifted length keeps only the low byte
	assign len_sel = phv_d1.ctrl.fix_len_tag ?
		parser_pkg::LEN_W'(len_masked << phv_d1.ctrl.len_shift) : phv_d1.ctrl.fix_len;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_d1    <= 1'b0;
			valid_d2    <= 1'b0;
			phv_valid_o <= 1'b0;
			phv_o       <= '0;
		end else begin
			valid_d1    <= valid_i;
			valid_d2    <= valid_d1;
			phv_valid_o <= valid_d2;
			phv_o.ctrl       <= hit_action_i;	// matched action drives the next stage
			phv_o.hdr_offset <= next_offset;
			phv_o.pkt_hdr    <= phv_d2.pkt_hdr;
		end
	end

	always_ff @(posedge clk) begin
		len_masked  <= len_field_i[parser_pkg::LEN_W-1:0] & phv_i.ctrl.len_mask;
		phv_d1      <= phv_i;
		next_offset <= phv_d1.hdr_offset + parser_pkg::OFFSET_W'(len_sel);	// wraps at 1 KB
		phv_d2      <= phv_d1;
	end

endmodule

/* parser_pkg.sv */
// parser widths and packet header vector types

package parser_pkg;

	localparam int HDR_W     = 512;	// packet header carried in every PHV
	localparam int HDR_BYTES = 64;
	localparam int OFFSET_W  = 10;	// header offset, wraps at 1 KB
	localparam int FIELD_W   = 16;	// type and length extractors
	localparam int LEN_W     = 8;
	localparam int EXT_OFF_W = 6;	// byte offset inside the located header, bit 0 ignored

	// parse instructions for the protocol at the current offset
	typedef struct packed {
		logic [EXT_OFF_W-1:0] type_off;
		logic [EXT_OFF_W-1:0] len_off;
		logic                 fix_len_tag;	// 0 fixed length, 1 computed from len field
		logic [1:0]           len_shift;
		logic [LEN_W-1:0]     fix_len;
		logic [LEN_W-1:0]     len_mask;
		logic [7:0]           next_hdr_type;	// 0 ends parsing
	} parse_ctrl_t;

	// byte 0 of pkt_hdr sits in the most significant byte
	typedef struct packed {
		parse_ctrl_t          ctrl;
		logic [OFFSET_W-1:0]  hdr_offset;
		logic [HDR_W-1:0]     pkt_hdr;
	} phv_t;

endpackage

/* parser_stage.sv */
// programmable parser stage top level

`timescale 1ns/10ps

module parser_stage #(
	parameter int RULE_NUM = 8
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                phv_valid_i,
	input  parser_pkg::phv_t    phv_i,
	output logic                phv_valid_o,
	output parser_pkg::phv_t    phv_o,
	input  rule_pkg::cfg_req_t  cfg_req_i,
	output rule_pkg::cfg_rsp_t  cfg_rsp_o
);

	logic                            loc_valid;
	parser_pkg::phv_t                loc_phv;
	logic [parser_pkg::HDR_W-1:0]    located;
	logic                            ext_valid;
	parser_pkg::phv_t                ext_phv;
	logic [parser_pkg::FIELD_W-1:0]  type_field;
	logic [parser_pkg::FIELD_W-1:0]  len_field;
	parser_pkg::parse_ctrl_t         hit_action;

	header_locator u_locator (
		.clk(clk), .reset(reset),
		.valid_i(phv_valid_i), .phv_i(phv_i),
		.valid_o(loc_valid), .phv_o(loc_phv), .located_o(located)
	);

	field_extractor u_extractor (
		.clk(clk), .reset(reset),
		.valid_i(loc_valid), .phv_i(loc_phv), .located_i(located),
		.valid_o(ext_valid), .phv_o(ext_phv),
		.type_field_o(type_field), .len_field_o(len_field)
	);

	rule_matcher #(.RULE_NUM(RULE_NUM)) u_matcher (
		.clk(clk), .reset(reset),
		.cfg_req_i(cfg_req_i), .cfg_rsp_o(cfg_rsp_o),
		.type_field_i(type_field), .hit_action_o(hit_action)
	);

	next_header_calc u_next_hdr (
		.clk(clk), .reset(reset),
		.valid_i(ext_valid), .phv_i(ext_phv),
		.len_field_i(len_field), .hit_action_i(hit_action),
		.phv_valid_o(phv_valid_o), .phv_o(phv_o)
	);

endmodule

/* rule_matcher.sv */
// rule table with masked parallel lookup
// highest matching index selects the action

`timescale 1ns/10ps

module rule_matcher #(
	parameter int RULE_NUM = 8
) (
	input  logic                            clk,
	input  logic                            reset,
	input  rule_pkg::cfg_req_t              cfg_req_i,
	output rule_pkg::cfg_rsp_t              cfg_rsp_o,
	input  logic [parser_pkg::FIELD_W-1:0]  type_field_i,
	output parser_pkg::parse_ctrl_t         hit_action_o
);

	logic [RULE_NUM-1:0]             rule_valid;
	logic [parser_pkg::FIELD_W-1:0]  rule_key    [RULE_NUM];
	logic [parser_pkg::FIELD_W-1:0]  rule_mask   [RULE_NUM];
	parser_pkg::parse_ctrl_t         rule_action [RULE_NUM];

	logic                            addr_ok;
	logic                            wr_en;
	logic                            rd_en;
	logic [RULE_NUM-1:0]             hit_bits;
	parser_pkg::parse_ctrl_t         hit_sel;
	rule_pkg::rule_entry_t           rd_entry;

	assign addr_ok = 32'(cfg_req_i.addr) < RULE_NUM;
	assign wr_en   = (cfg_req_i.op == rule_pkg::CFG_WRITE) && addr_ok;
	assign rd_en   = (cfg_req_i.op == rule_pkg::CFG_READ);

	always_comb begin
		rd_entry = '0;	// out of range reads return zero
		if (addr_ok) begin
			rd_entry.valid  = rule_valid[cfg_req_i.addr];
			rd_entry.key    = rule_key[cfg_req_i.addr];
			rd_entry.mask   = rule_mask[cfg_req_i.addr];
			rd_entry.action = rule_action[cfg_req_i.addr];
		end
	end

	// valid bits and the response port
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rule_valid <= '0;
			cfg_rsp_o  <= '0;
		end else begin
			if (wr_en)
				rule_valid[cfg_req_i.addr] <= cfg_req_i.data.valid;
			cfg_rsp_o.valid <= rd_en;
			if (rd_en)
				cfg_rsp_o.data <= rd_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			rule_key[cfg_req_i.addr]    <= cfg_req_i.data.key;
			rule_mask[cfg_req_i.addr]   <= cfg_req_i.data.mask;
			rule_action[cfg_req_i.addr] <= cfg_req_i.data.action;
		end
	end

	// compare against every entry at once
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			hit_bits <= '0;
		end else begin
			for (int i = 0; i < RULE_NUM; i++) begin
				hit_bits[i] <= rule_valid[i] && ((type_field_i & rule_mask[i]) == rule_key[i]);
			end
		end
	end

	always_comb begin
		hit_sel = '0;	// no hit gives an empty action
		for (int i = 0; i < RULE_NUM; i++) begin
			if (hit_bits[i])
				hit_sel = rule_action[i];	// later index overrides
		end
	end

	always_ff @(posedge clk) begin
		hit_action_o <= hit_sel;
	end

	assert property (@(posedge clk) disable iff (!reset)
		cfg_rsp_o.valid == $past(cfg_req_i.op == rule_pkg::CFG_READ))
		else $error("read response not one cycle after a read request");

	// a hit must come from a rule that was valid at compare time
	assert property (@(posedge clk) disable iff (!reset)
		(hit_bits & ~$past(rule_valid)) == '0)
		else $error("hit reported for an invalid rule");

endmodule

/* rule_pkg.sv */
// rule table entry and configuration port types

package rule_pkg;

	localparam int RULE_ADDR_W = 3;

	typedef enum logic [1:0] {
		CFG_IDLE,
		CFG_WRITE,
		CFG_READ
	} cfg_op_e;

	// a rule hits when valid and (type & mask) == key
	typedef struct packed {
		logic                             valid;
		logic [parser_pkg::FIELD_W-1:0]   key;
		logic [parser_pkg::FIELD_W-1:0]   mask;
		parser_pkg::parse_ctrl_t          action;
	} rule_entry_t;

	typedef struct packed {
		cfg_op_e                  op;
		logic [RULE_ADDR_W-1:0]   addr;
		rule_entry_t              data;	// used by writes only
	} cfg_req_t;

	typedef struct packed {
		logic         valid;	// one cycle after a read
		rule_entry_t  data;
	} cfg_rsp_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# build and run the parser stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_parser_stage -o sim_parser
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_parser)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

/* tb_clock_gen.sv */
// testbench clock and reset

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b0;	// active low
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b1;
	end

endmodule

/* tb_parser_stage.sv */
// parser stage testbench
// random vectors checked against a reference model

`timescale 1ns/10ps

module tb_parser_stage;

	localparam int RULE_NUM  = 8;
	localparam int LATENCY   = 7;
	localparam int PERIOD_NS = 8;
	localparam int CMP_W     = 1024;
	// cycles for reset, config, no hit, random, priority and latency tests
	localparam int BUDGET    = 24 + 40 + 48 + (16 + 200 * 4 + 12) + 38 + 60;
	localparam int MARGIN    = 200;

	logic                   clk;
	logic                   reset;
	logic                   phv_valid_i;
	parser_pkg::phv_t       phv_i;
	logic                   phv_valid_o;
	parser_pkg::phv_t       phv_o;
	rule_pkg::cfg_req_t     cfg_req_i;
	rule_pkg::cfg_rsp_t     cfg_rsp_o;

	integer                 seed;
	int                     cycle_cnt = 0;
	int                     err_cnt   = 0;
	int                     chk_cnt   = 0;
	int                     test_cnt  = 0;
	int                     err_mark  = 0;
	rule_pkg::rule_entry_t  shadow [RULE_NUM];	// host copy of the rule table
	parser_pkg::phv_t       exp_q[$];
	int                     due_q[$];

	tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(16)) u_clk_gen (
		.clk_o(clk), .reset_o(reset)
	);

	parser_stage #(.RULE_NUM(RULE_NUM)) DUT (
		.clk(clk), .reset(reset),
		.phv_valid_i(phv_valid_i), .phv_i(phv_i),
		.phv_valid_o(phv_valid_o), .phv_o(phv_o),
		.cfg_req_i(cfg_req_i), .cfg_rsp_o(cfg_rsp_o)
	);

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	function automatic logic [127:0] rand128();
		return {rand32(), rand32(), rand32(), rand32()};
	endfunction

	function automatic parser_pkg::phv_t rand_phv();
		parser_pkg::phv_t v;
		logic [127:0]     r;
		r            = rand128();
		v.ctrl       = r[$bits(parser_pkg::parse_ctrl_t)-1:0];
		v.hdr_offset = r[127 -: parser_pkg::OFFSET_W];
		for (int i = 0; i < parser_pkg::HDR_W / 32; i++)
			v.pkt_hdr[i*32 +: 32] = rand32();
		return v;
	endfunction

	function automatic rule_pkg::rule_entry_t rand_entry();
		rule_pkg::rule_entry_t e;
		logic [127:0]          r;
		r     = rand128();
		e     = r[$bits(rule_pkg::rule_entry_t)-1:0];
		e.key = e.key & e.mask;	// key kept inside its mask
		return e;
	endfunction

	// byte k of the located header, byte 0 at the top of pkt_hdr
	function automatic logic [7:0] located_byte(input parser_pkg::phv_t v, input int k);
		int p;
		p = (k + int'(v.hdr_offset)) % parser_pkg::HDR_BYTES;
		return v.pkt_hdr[parser_pkg::HDR_W - 8 - 8 * p +: 8];
	endfunction

	function automatic logic [15:0] located_field(input parser_pkg::phv_t v,
			input logic [5:0] off);
		int t;
		t = int'({off[5:1], 1'b0});
		return {located_byte(v, t), located_byte(v, t + 1)};
	endfunction

	// writes a type value where the type extractor will find it
	function automatic parser_pkg::phv_t place_type(input parser_pkg::phv_t v,
			input logic [15:0] val);
		int t;
		int p;
		t = int'({v.ctrl.type_off[5:1], 1'b0});
		for (int j = 0; j < 2; j++) begin
			p = (t + j + int'(v.hdr_offset)) % parser_pkg::HDR_BYTES;
			v.pkt_hdr[parser_pkg::HDR_W - 8 - 8 * p +: 8] = val[15 - 8 * j -: 8];
		end
		return v;
	endfunction

	function automatic parser_pkg::phv_t predict(input parser_pkg::phv_t v);
		parser_pkg::phv_t r;
		logic [15:0]      type_f;
		logic [15:0]      len_f;
		logic [7:0]       len;
		type_f = located_field(v, v.ctrl.type_off);
		len_f  = located_field(v, v.ctrl.len_off);
		r      = v;
		r.ctrl = '0;
		for (int i = 0; i < RULE_NUM; i++)
			if (shadow[i].valid && (type_f & shadow[i].mask) == shadow[i].key)
				r.ctrl = shadow[i].action;	// highest index wins
		len = v.ctrl.fix_len_tag ? (len_f[7:0] & v.ctrl.len_mask) << v.ctrl.len_shift
			: v.ctrl.fix_len;
		r.hdr_offset = v.hdr_offset + {2'b00, len};
		return r;
	endfunction

	task automatic check(input logic [CMP_W-1:0] got, input logic [CMP_W-1:0] exp,
			input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s mismatch, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			phv_valid_i <= 1'b0;
			cfg_req_i   <= '0;
		end
	endtask

	task automatic send_vector(input parser_pkg::phv_t v);
		@(posedge clk);
		phv_valid_i <= 1'b1;
		phv_i       <= v;
		exp_q.push_back(predict(v));
		due_q.push_back(cycle_cnt + LATENCY + 1);	// one edge for the DUT to sample
	endtask

	task automatic write_rule(input int addr, input rule_pkg::rule_entry_t e);
		rule_pkg::cfg_req_t req;
		req.op   = rule_pkg::CFG_WRITE;
		req.addr = rule_pkg::RULE_ADDR_W'(addr);
		req.data = e;
		@(posedge clk);
		cfg_req_i    <= req;
		shadow[addr]  = e;
		idle(1);
	endtask

	task automatic read_rule(input int addr);
		rule_pkg::cfg_req_t req;
		req      = '0;
		req.op   = rule_pkg::CFG_READ;
		req.addr = rule_pkg::RULE_ADDR_W'(addr);
		@(posedge clk);
		cfg_req_i <= req;
		idle(1);
		check(CMP_W'(cfg_rsp_o.valid), '0, "early read response");
		@(posedge clk);
		check(CMP_W'(cfg_rsp_o.valid), CMP_W'(1), "read response valid");
		check(CMP_W'(cfg_rsp_o.data), CMP_W'(shadow[addr]), "read data");
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (due_q.size() > 0 && waited < 2 * LATENCY + 4) begin
			@(posedge clk);
			phv_valid_i <= 1'b0;
			waited++;
		end
		if (due_q.size() > 0) begin
			err_cnt++;
			$display("outputs still missing at %0t after the drain timeout", $time);
			exp_q.delete();
			due_q.delete();
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	// output monitor, every pulse must match the oldest vector in flight
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (phv_valid_o) begin
			if (due_q.size() == 0) begin
				err_cnt++;
				$display("output vector at %0t with no vector in flight", $time);
			end else begin
				check(CMP_W'(cycle_cnt), CMP_W'(due_q[0]), "output latency");
				check(CMP_W'(phv_o), CMP_W'(exp_q[0]), "output vector");
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
		end else if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
			err_cnt++;
			$display("expected output vector missing at %0t", $time);
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
		end
	end

	initial begin
		#((BUDGET + MARGIN) * PERIOD_NS);
		$display("simulation timed out after %0d cycles", BUDGET + MARGIN);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		rule_pkg::rule_entry_t e;
		parser_pkg::phv_t      v;
		logic [15:0]           val;
		int                    r;
		int                    burst_run;
		seed        = 32'h59ff;
		phv_valid_i = 1'b0;
		phv_i       = '0;
		cfg_req_i   = '0;
		for (int i = 0; i < RULE_NUM; i++)
			shadow[i] = '0;

		// outputs stay quiet through reset and after it
		@(posedge clk);
		do begin
			@(posedge clk);
			check(CMP_W'(phv_valid_o), '0, "phv_valid_o during reset");
			check(CMP_W'(cfg_rsp_o.valid), '0, "cfg_rsp_o.valid during reset");
		end while (!reset);
		repeat (4) begin
			idle(1);
			check(CMP_W'(phv_valid_o), '0, "phv_valid_o after reset");
			check(CMP_W'(cfg_rsp_o.valid), '0, "cfg_rsp_o.valid after reset");
		end
		end_test("reset");

		for (int i = 0; i < RULE_NUM; i++)
			write_rule(i, rand_entry());
		for (int i = 0; i < RULE_NUM; i++)
			read_rule(i);
		end_test("configuration");

		for (int i = 0; i < RULE_NUM; i++) begin
			e       = rand_entry();
			e.valid = 1'b0;
			write_rule(i, e);
		end
		repeat (20) send_vector(rand_phv());
		wait_drain();
		end_test("no hit");

		for (int i = 0; i < RULE_NUM; i++) begin
			e       = rand_entry();
			e.valid = (rand32() % 8) != 0;	// mostly live rules
			write_rule(i, e);
		end
		for (int n = 0; n < 200; n++) begin
			v = rand_phv();
			r = rand32() % RULE_NUM;
			if (rand32() % 4 != 0)
				v = place_type(v, shadow[r].key | (16'(rand32()) & ~shadow[r].mask));
			send_vector(v);
			if (rand32() % 3 == 0)
				idle(int'(1 + rand32() % 3));	// gapped traffic
		end
		wait_drain();
		end_test("random parsing");

		// rules 1, 4 and 7 all match the same type value
		val = 16'(rand32());
		for (int i = 0; i < RULE_NUM; i++) begin
			e       = rand_entry();
			e.valid = (i % 3) == 1;
			e.key   = val & e.mask;
			write_rule(i, e);
		end
		repeat (10) send_vector(place_type(rand_phv(), val));
		wait_drain();
		end_test("priority");

		// outputs start before the input burst ends, so count while sending
		burst_run = 0;
		fork
			begin
				repeat (16) send_vector(rand_phv());
				idle(1);
			end
			begin
				for (int w = 0; w < 2 * LATENCY + 24 && burst_run < 16; w++) begin
					@(posedge clk);
					if (phv_valid_o)
						burst_run++;
					else if (burst_run > 0)
						break;
				end
			end
		join
		check(CMP_W'(burst_run), CMP_W'(16), "back-to-back output run");
		wait_drain();
		end_test("latency");

		$display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* verilog.f */
parser_pkg.sv
rule_pkg.sv
header_locator.sv
field_extractor.sv
rule_matcher.sv
next_header_calc.sv
parser_stage.sv
tb_clock_gen.sv
tb_parser_stage.sv
